// File: hw/bubl_consts.svh
// Bubble Bobble main-board constants
// Bus widths, memory-map windows and fixed register values shared by
// the packages and the bus slaves

`ifndef BUBL_CONSTS_SVH
`define BUBL_CONSTS_SVH

// Widths
`define BUBL_AW             16          // CPU address
`define BUBL_DW             8           // CPU data
`define BUBL_RAM_AW         13          // 8 KB work RAM offset

// Main CPU windows
`define BUBL_MAIN_RAM_BASE  16'hE000
`define BUBL_MAIN_RAM_LAST  16'hF7FF
`define BUBL_SOUND_BASE     16'hFA00    // Offsets 0..3
`define BUBL_WDOG_BASE      16'hFA80
`define BUBL_NMI_ADDR       16'hFB00
`define BUBL_MISC_ADDR      16'hFB40

// Sub CPU window, runs up to FFFF
`define BUBL_SUB_RAM_BASE   16'hE000

// Register values
`define BUBL_BANK_XOR       3'd4
`define BUBL_WDOG_W         8           // Top bit marks expiry
`define BUBL_OPEN_BUS       8'hFF

`endif

// File: hw/bubl_bus_pkg.sv
// CPU bus types
// APB request and response carried between each CPU side and its
// bus slave on the main board

`include "bubl_consts.svh"

package bubl_bus_pkg;

    // Master side, held stable until pready
    typedef struct packed {
        logic                psel;
        logic                penable;
        logic                pwrite;
        logic [`BUBL_AW-1:0] paddr;
        logic [`BUBL_DW-1:0] pwdata;
    } apb_req_t;

    // Slave side
    typedef struct packed {
        logic [`BUBL_DW-1:0] prdata;
        logic                pready;
    } apb_rsp_t;

endpackage

// File: hw/bubl_ctrl_pkg.sv
// Board-side types
// Work-RAM request and response between the CPU ports and the shared
// RAM, plus the control and sound outputs of the main port

`include "bubl_consts.svh"

package bubl_ctrl_pkg;

    // Port to RAM, held until ack
    typedef struct packed {
        logic                    valid;
        logic                    we;
        logic [`BUBL_RAM_AW-1:0] addr;
        logic [`BUBL_DW-1:0]     wdata;
    } ram_req_t;

    typedef struct packed {
        logic                ack;
        logic [`BUBL_DW-1:0] rdata;    // Valid with ack
    } ram_rsp_t;

    // Misc register fields
    typedef struct packed {
        logic [2:0] bank;
        logic       flip;
        logic       black_n;
        logic       sub_run;
    } board_ctrl_t;

    typedef struct packed {
        logic [`BUBL_DW-1:0] latch;    // Byte for the sound CPU
        logic                stb;
        logic                rst;
    } snd_out_t;

endpackage

// File: hw/bubl_main_port.sv
// Main CPU bus slave
// Decodes the main memory map, forwards work-RAM accesses, holds the
// misc control and sound registers, pulses the sub-CPU NMI and runs
// the vertical-blank watchdog

`timescale 1ns/10ps
`include "bubl_consts.svh"

module bubl_main_port (
    input  logic                        clk,
    input  logic                        rst,
    input  bubl_bus_pkg::apb_req_t      bus,
    output bubl_bus_pkg::apb_rsp_t      rsp,
    output bubl_ctrl_pkg::ram_req_t     ram_req,
    input  bubl_ctrl_pkg::ram_rsp_t     ram_rsp,
    input  logic                        vbl,
    input  logic [`BUBL_DW-1:0]         main_latch,
    output bubl_ctrl_pkg::board_ctrl_t  ctrl,
    output bubl_ctrl_pkg::snd_out_t     snd,
    output logic                        sub_nmi,
    output logic                        main_reset
);

    typedef enum logic {ST_IDLE, ST_RAM} ram_st_t;

    localparam logic [`BUBL_AW-1:0] SND_BASE = `BUBL_SOUND_BASE;

    ram_st_t                 ram_st;
    logic                    access;
    logic                    wr;            // Register write, done this cycle
    logic                    ram_cs, snd_cs, wdog_cs, nmi_cs, misc_cs;
    logic [1:0]              snd_off;
    logic                    vbl_q;
    logic                    vbl_fall;
    logic [`BUBL_WDOG_W-1:0] wdog_cnt;
    logic                    wdog_exp;

    ////////////////////////////////////////////////////////////////////////////
    // Address decoder

    always_comb begin
        ram_cs  = bus.paddr >= `BUBL_MAIN_RAM_BASE && bus.paddr <= `BUBL_MAIN_RAM_LAST;
        snd_cs  = bus.paddr[`BUBL_AW-1:2] == SND_BASE[`BUBL_AW-1:2];
        wdog_cs = bus.paddr == `BUBL_WDOG_BASE;
        nmi_cs  = bus.paddr == `BUBL_NMI_ADDR;
        misc_cs = bus.paddr == `BUBL_MISC_ADDR;
        snd_off = bus.paddr[1:0];
    end

    assign access = bus.psel && bus.penable;
    assign wr     = access && bus.pwrite && !ram_cs;

    // Work-RAM request stays up until ack
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram_st <= ST_IDLE;
        end else begin
            case (ram_st)
                ST_IDLE: if (ram_req.valid) ram_st <= ST_RAM;
                ST_RAM:  if (ram_rsp.ack) ram_st <= ST_IDLE;
                default: ram_st <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        ram_req.valid = (ram_st == ST_RAM) || (access && ram_cs);
        ram_req.we    = bus.pwrite;
        ram_req.addr  = bus.paddr[`BUBL_RAM_AW-1:0];
        ram_req.wdata = bus.pwdata;
    end

    // Registers and open bus answer at once, RAM waits for ack
    always_comb begin
        rsp.pready = access && (!ram_cs || (ram_st == ST_RAM && ram_rsp.ack));
        if (ram_cs)
            rsp.prdata = ram_rsp.rdata;
        else if (snd_cs && snd_off == 2'd0)
            rsp.prdata = main_latch;    // Sound CPU reply
        else
            rsp.prdata = `BUBL_OPEN_BUS;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control and sound registers, also cleared by the watchdog

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl    <= '0;
            snd     <= '0;
            sub_nmi <= 1'b0;
        end else if (wdog_exp) begin
            ctrl    <= '0;
            snd     <= '0;
            sub_nmi <= 1'b0;
        end else begin
            snd.stb <= wr && snd_cs && snd_off == 2'd0;
            sub_nmi <= wr && nmi_cs;
            if (wr && snd_cs && snd_off == 2'd0)
                snd.latch <= bus.pwdata;
            if (wr && snd_cs && snd_off == 2'd3)
                snd.rst <= bus.pwdata[0];
            if (wr && misc_cs) begin
                ctrl.bank    <= bus.pwdata[2:0] ^ `BUBL_BANK_XOR;
                ctrl.sub_run <= bus.pwdata[4];
                ctrl.black_n <= bus.pwdata[6];
                ctrl.flip    <= bus.pwdata[7];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Watchdog

    assign vbl_fall = vbl_q && !vbl;
    assign wdog_exp = wdog_cnt[`BUBL_WDOG_W-1];  // 128 blanks without a kick

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vbl_q    <= 1'b0;
            wdog_cnt <= '0;
        end else begin
            vbl_q <= vbl;
            if (wdog_exp || (access && wdog_cs))
                wdog_cnt <= '0;
            else if (vbl_fall)
                wdog_cnt <= wdog_cnt + 1'b1;
        end
    end

    assign main_reset = wdog_exp;   // One clock, count restarts after it

endmodule

// File: hw/bubl_sub_port.sv
// Sub CPU bus slave
// Forwards the E000-FFFF work-RAM window to the shared RAM and answers
// every other address at once with open bus

`timescale 1ns/10ps
`include "bubl_consts.svh"

module bubl_sub_port (
    input  logic                    clk,
    input  logic                    rst,
    input  bubl_bus_pkg::apb_req_t  bus,
    output bubl_bus_pkg::apb_rsp_t  rsp,
    output bubl_ctrl_pkg::ram_req_t ram_req,
    input  bubl_ctrl_pkg::ram_rsp_t ram_rsp
);

    typedef enum logic {ST_IDLE, ST_RAM} ram_st_t;

    ram_st_t ram_st;
    logic    access;
    logic    ram_cs;

    assign access = bus.psel && bus.penable;
    assign ram_cs = bus.paddr >= `BUBL_SUB_RAM_BASE;   // Up to the top of the map

    // Outstanding RAM request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram_st <= ST_IDLE;
        end else begin
            case (ram_st)
                ST_IDLE: if (ram_req.valid) ram_st <= ST_RAM;
                ST_RAM:  if (ram_rsp.ack) ram_st <= ST_IDLE;
                default: ram_st <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        ram_req.valid = (ram_st == ST_RAM) || (access && ram_cs);
        ram_req.we    = bus.pwrite;
        ram_req.addr  = bus.paddr[`BUBL_RAM_AW-1:0];
        ram_req.wdata = bus.pwdata;
    end

    // Unmapped writes fall on the floor
    always_comb begin
        rsp.pready = access && (!ram_cs || (ram_st == ST_RAM && ram_rsp.ack));
        rsp.prdata = ram_cs ? ram_rsp.rdata : `BUBL_OPEN_BUS;
    end

endmodule

// File: hw/bubl_work_ram.sv
// Shared work RAM
// 8 KB single-access RAM between the main and sub CPU ports. Main wins
// unless the sub side already owns the RAM; one access per cycle with
// registered read data and ack

`timescale 1ns/10ps
`include "bubl_consts.svh"

module bubl_work_ram (
    input  logic                    clk,
    input  logic                    rst,
    input  bubl_ctrl_pkg::ram_req_t main_req,
    input  bubl_ctrl_pkg::ram_req_t sub_req,
    output bubl_ctrl_pkg::ram_rsp_t main_rsp,
    output bubl_ctrl_pkg::ram_rsp_t sub_rsp
);

    import bubl_ctrl_pkg::*;

    localparam int DEPTH = 1 << `BUBL_RAM_AW;

    logic [`BUBL_DW-1:0] mem [0:DEPTH-1];
    logic [`BUBL_DW-1:0] rdata_q;
    logic                main_ack, sub_ack;
    logic                sub_own;       // Sub CPU holds the RAM
    logic                gnt_main, gnt_sub;
    ram_req_t            sel;

    // A port waiting on its ack is not served again
    assign gnt_main = main_req.valid && !main_ack && !sub_own;
    assign gnt_sub  = sub_req.valid && !sub_ack && !gnt_main;
    assign sel      = gnt_main ? main_req : sub_req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            main_ack <= 1'b0;
            sub_ack  <= 1'b0;
            sub_own  <= 1'b0;
        end else begin
            main_ack <= gnt_main;
            sub_ack  <= gnt_sub;
            if (gnt_sub && !main_req.valid)
                sub_own <= 1'b1;
            else if (sub_ack)
                sub_own <= 1'b0;    // Sub request finished
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (gnt_main || gnt_sub) begin
            if (sel.we)
                mem[sel.addr] <= sel.wdata;
            rdata_q <= mem[sel.addr];
        end
    end

    // Only one side acks in a cycle, so the read register is shared
    always_comb begin
        main_rsp.ack   = main_ack;
        main_rsp.rdata = rdata_q;
        sub_rsp.ack    = sub_ack;
        sub_rsp.rdata  = rdata_q;
    end

endmodule

// File: hw/bubl_main_board.sv
// Bubble Bobble main-board glue
// Main and sub CPU bus slaves around the shared work RAM

`timescale 1ns/10ps
`include "bubl_consts.svh"

module bubl_main_board (
    input  logic                        clk,
    input  logic                        rst,
    input  bubl_bus_pkg::apb_req_t      main_bus,
    output bubl_bus_pkg::apb_rsp_t      main_rsp,
    input  bubl_bus_pkg::apb_req_t      sub_bus,
    output bubl_bus_pkg::apb_rsp_t      sub_rsp,
    input  logic                        vbl,
    input  logic [`BUBL_DW-1:0]         main_latch,
    output bubl_ctrl_pkg::board_ctrl_t  ctrl,
    output bubl_ctrl_pkg::snd_out_t     snd,
    output logic                        sub_nmi,
    output logic                        main_reset
);

    import bubl_ctrl_pkg::*;

    ram_req_t main_ram_req, sub_ram_req;
    ram_rsp_t main_ram_rsp, sub_ram_rsp;

    bubl_main_port u_main_port (
        .clk        (clk),
        .rst        (rst),
        .bus        (main_bus),
        .rsp        (main_rsp),
        .ram_req    (main_ram_req),
        .ram_rsp    (main_ram_rsp),
        .vbl        (vbl),
        .main_latch (main_latch),
        .ctrl       (ctrl),
        .snd        (snd),
        .sub_nmi    (sub_nmi),
        .main_reset (main_reset)
    );

    bubl_sub_port u_sub_port (
        .clk     (clk),
        .rst     (rst),
        .bus     (sub_bus),
        .rsp     (sub_rsp),
        .ram_req (sub_ram_req),
        .ram_rsp (sub_ram_rsp)
    );

    bubl_work_ram u_work_ram (
        .clk      (clk),
        .rst      (rst),
        .main_req (main_ram_req),
        .sub_req  (sub_ram_req),
        .main_rsp (main_ram_rsp),
        .sub_rsp  (sub_ram_rsp)
    );

endmodule

// File: verification/tb_bubl_main_board.sv
// Testbench for the Bubble Bobble main-board glue
// Table-driven APB transfers on both CPU buses, misc control and sound
// outputs, shared work RAM traffic and the vertical-blank watchdog

`timescale 1ns/10ps
`include "bubl_consts.svh"

module tb_bubl_main_board;

    import bubl_bus_pkg::*;
    import bubl_ctrl_pkg::*;

    localparam logic MAIN = 1'b0;
    localparam logic SUB  = 1'b1;
    localparam logic RD   = 1'b0;
    localparam logic WR   = 1'b1;

    typedef struct packed {
        logic        sub;       // 1 for the sub CPU bus
        logic        wr;
        logic        pair;      // Launch together with the next entry
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  want;      // Expected read data
    } step_t;

    logic        clk;
    logic        rst;
    apb_req_t    main_bus, sub_bus;
    apb_rsp_t    main_rsp, sub_rsp;
    logic        vbl;
    logic [7:0]  main_latch;
    board_ctrl_t ctrl, exp_ctrl;
    snd_out_t    snd, exp_snd;
    logic        sub_nmi, main_reset;
    logic [31:0] lcg_state = 32'h24fc_2731;
    int          resets_seen = 0;
    step_t       steps[$];

    bubl_main_board u_bubl_main_board (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        if (main_reset)
            resets_seen++;      // Watchdog pulses
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [7:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, want);
            stop_with_failure();
        end
    endtask

    function automatic void add_step(input logic sub, input logic wr, input logic pair,
                                     input logic [15:0] addr, input logic [7:0] data,
                                     input logic [7:0] want);
        steps.push_back(step_t'{sub, wr, pair, addr, data, want});
    endfunction

    task automatic drive_bus(input logic sub, input apb_req_t req);
        if (sub)
            sub_bus = req;
        else
            main_bus = req;
    endtask

    // One APB transfer, read data checked against the entry
    task automatic apply_step(input step_t s);
        apb_req_t req;
        apb_rsp_t rsp;
        string    name;
        int       waited;
        req = '{psel: 1'b1, penable: 1'b0, pwrite: s.wr, paddr: s.addr, pwdata: s.data};
        name = s.sub ? "sub" : "main";
        @(negedge clk);
        drive_bus(s.sub, req);      // Setup
        @(negedge clk);
        req.penable = 1'b1;
        drive_bus(s.sub, req);
        waited = 0;
        #1;
        rsp = s.sub ? sub_rsp : main_rsp;
        while (!rsp.pready) begin
            if (waited == 64) begin
                $display("Timeout: no pready on the %s bus after 64 cycles", name);
                stop_with_failure();
            end
            waited++;
            @(negedge clk);
            #1;
            rsp = s.sub ? sub_rsp : main_rsp;
        end
        if (!s.wr)
            check_value({name, "_rsp.prdata"}, 32'(rsp.prdata), 32'(s.want));
        @(negedge clk);
        drive_bus(s.sub, '0);
    endtask

    task automatic main_write(input logic [15:0] addr, input logic [7:0] data);
        apply_step(step_t'{MAIN, WR, 1'b0, addr, data, 8'h00});
    endtask

    task automatic pulse_vbl();
        @(negedge clk);
        vbl = 1'b1;
        @(negedge clk);
        vbl = 1'b0;
        @(negedge clk);         // Falling edge counted by now
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    initial begin
        logic [7:0]  d, da, db, dc, dd;
        logic [12:0] off_a, off_b;
        step_t       s0, s1;
        int          waited;
        rst = 1'b1;
        main_bus = '0;
        sub_bus = '0;
        vbl = 1'b0;
        main_latch = next_rand();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("ctrl", 32'(ctrl), 32'h0);
        check_value("snd", 32'(snd), 32'h0);
        check_value("sub_nmi", 32'(sub_nmi), 32'h0);
        check_value("main_reset", 32'(main_reset), 32'h0);
        check_value("pready", 32'({main_rsp.pready, sub_rsp.pready}), 32'h0);

        repeat (4) begin
            d = next_rand();
            main_write(`BUBL_MISC_ADDR, d);
            exp_ctrl = '{bank: d[2:0] ^ 3'd4, flip: d[7], black_n: d[6], sub_run: d[4]};
            check_value("ctrl", 32'(ctrl), 32'(exp_ctrl));
        end

        // Sound latch strobe and sub NMI, one clock each
        d = next_rand();
        check_value("snd.stb", 32'(snd.stb), 32'h0);
        main_write(`BUBL_SOUND_BASE, d);
        check_value("snd.latch", 32'(snd.latch), 32'(d));
        check_value("snd.stb", 32'(snd.stb), 32'h1);
        @(negedge clk);
        check_value("snd.stb", 32'(snd.stb), 32'h0);
        main_write(`BUBL_SOUND_BASE + 16'd3, 8'h01);
        check_value("snd.rst", 32'(snd.rst), 32'h1);
        main_write(`BUBL_NMI_ADDR, next_rand());
        check_value("sub_nmi", 32'(sub_nmi), 32'h1);
        @(negedge clk);
        check_value("sub_nmi", 32'(sub_nmi), 32'h0);
        exp_snd = '{latch: d, stb: 1'b0, rst: 1'b1};

        add_step(MAIN, RD, 1'b0, `BUBL_SOUND_BASE, 8'h00, main_latch);
        add_step(MAIN, RD, 1'b0, `BUBL_SOUND_BASE + 16'd1, 8'h00, `BUBL_OPEN_BUS);
        add_step(MAIN, WR, 1'b0, 16'h0100, next_rand(), 8'h00);
        add_step(MAIN, RD, 1'b0, 16'h0100, 8'h00, `BUBL_OPEN_BUS);
        add_step(SUB,  WR, 1'b0, 16'h4000, next_rand(), 8'h00);
        add_step(SUB,  RD, 1'b0, 16'h4000, 8'h00, `BUBL_OPEN_BUS);
        repeat (6) begin
            off_a = 13'({next_rand(), next_rand()}) & 13'h0FFF;
            off_b = off_a ^ 13'h0800;   // Distinct, still inside the main window
            da = next_rand();
            db = next_rand();
            dc = next_rand();
            dd = next_rand();
            add_step(MAIN, WR, 1'b0, `BUBL_MAIN_RAM_BASE + 16'(off_a), da, 8'h00);
            add_step(SUB,  RD, 1'b0, `BUBL_SUB_RAM_BASE + 16'(off_a), 8'h00, da);
            add_step(SUB,  WR, 1'b0, `BUBL_SUB_RAM_BASE + 16'(off_b), db, 8'h00);
            add_step(MAIN, RD, 1'b0, `BUBL_MAIN_RAM_BASE + 16'(off_b), 8'h00, db);
            add_step(MAIN, WR, 1'b1, `BUBL_MAIN_RAM_BASE + 16'(off_a), dc, 8'h00);
            add_step(SUB,  WR, 1'b0, `BUBL_SUB_RAM_BASE + 16'(off_b), dd, 8'h00);
            add_step(MAIN, RD, 1'b1, `BUBL_MAIN_RAM_BASE + 16'(off_b), 8'h00, dd);
            add_step(SUB,  RD, 1'b0, `BUBL_SUB_RAM_BASE + 16'(off_a), 8'h00, dc);
        end

        for (int i = 0; i < steps.size(); i++) begin
            if (steps[i].pair) begin
                s0 = steps[i];
                s1 = steps[i + 1];
                fork
                    apply_step(s0);
                    apply_step(s1);
                join
                i++;
            end else begin
                apply_step(steps[i]);
            end
        end
        check_value("ctrl", 32'(ctrl), 32'(exp_ctrl));     // Unmapped writes left it alone
        check_value("snd", 32'(snd), 32'(exp_snd));

        ////////////////////////////////////////////////////////////////////////
        // Watchdog

        repeat (60) begin
            repeat (3) pulse_vbl();
            main_write(`BUBL_WDOG_BASE, next_rand());
        end
        check_value("main_reset pulses", resets_seen, 32'd0);
        main_write(`BUBL_MISC_ADDR, 8'hFF);
        exp_ctrl = '{bank: 3'd3, flip: 1'b1, black_n: 1'b1, sub_run: 1'b1};
        repeat (127) pulse_vbl();
        check_value("main_reset", 32'(main_reset), 32'h0);
        check_value("ctrl", 32'(ctrl), 32'(exp_ctrl));
        pulse_vbl();
        waited = 0;
        while (!main_reset) begin
            if (waited == 64) begin
                $display("Timeout: main_reset never rose after 128 blanks without a kick");
                stop_with_failure();
            end
            waited++;
            @(negedge clk);
        end
        @(negedge clk);
        check_value("ctrl", 32'(ctrl), 32'h0);
        check_value("snd", 32'(snd), 32'h0);
        check_value("main_reset", 32'(main_reset), 32'h0);
        check_value("main_reset pulses", resets_seen, 32'd1);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hw
hw/bubl_bus_pkg.sv
hw/bubl_ctrl_pkg.sv
hw/bubl_main_port.sv
hw/bubl_sub_port.sv
hw/bubl_work_ram.sv
hw/bubl_main_board.sv
verification/tb_bubl_main_board.sv

// File: run.sh
#!/bin/sh
# Build and run the main-board testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/10ps --top-module tb_bubl_main_board -f vlog.f
./obj_dir/Vtb_bubl_main_board > sim.log 2>&1 || true
cat sim.log
if grep -qx "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
